/* common/serial_alu_pkg.sv */
package serial_alu_pkg;

   // Datapath and pass counter widths.
   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   // ####################
   // Opcodes and states
   // ####################

   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLT  = 4'd5,
      OP_SLTU = 4'd6,
      OP_EQ   = 4'd7,
      OP_SLL  = 4'd8,
      OP_SRL  = 4'd9,
      OP_SRA  = 4'd10
   } alu_op_e;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_FILL = 2'd1,
      ST_RUN  = 2'd2,
      ST_DONE = 2'd3
   } alu_state_e;

   // ####################
   // Datapath encodings
   // ####################

   // Index is {bool_sel, a, b}. Select 0 is AND, 1 is OR, 2 is XOR.
   localparam logic [15:0] BOOL_LUT = 16'h06E8;

   // Result bit source.
   localparam logic [1:0] RD_SEL_ADD  = 2'd0;
   localparam logic [1:0] RD_SEL_SH   = 2'd1;
   localparam logic [1:0] RD_SEL_LT   = 2'd2;
   localparam logic [1:0] RD_SEL_BOOL = 2'd3;

endpackage

/* verilog/bit_counter.sv */
`timescale 1ns/1ps

module bit_counter
   import serial_alu_pkg::*;
(
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_en,
   output logic [CNT_W-1:0] o_cnt,
   output logic             o_first,
   output logic             o_last
);

   // Wraps from 31 to 0 at the end of each pass.
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_cnt <= '0;
      end else if (i_en) begin
         o_cnt <= o_cnt + 1'b1;
      end
   end

   assign o_first = (o_cnt == '0);
   assign o_last  = (o_cnt == '1);

   a_first_last_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(o_first && o_last));

endmodule

/* verilog/operand_shreg.sv */
`timescale 1ns/1ps

module operand_shreg
   import serial_alu_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_load,
   input  logic            i_shift,
   input  logic [XLEN-1:0] i_d,
   input  logic            i_ser_in,
   input  logic            i_recirc,
   output logic            o_ser,
   output logic [XLEN-1:0] o_q
);

   logic msb_in;

   // Operands rotate so they survive the fill pass.
   assign msb_in = i_recirc ? o_q[0] : i_ser_in;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_q <= '0;
      end else if (i_load) begin
         o_q <= i_d;
      end else if (i_shift) begin
         o_q <= {msb_in, o_q[XLEN-1:1]};
      end
   end

   // LSB first.
   assign o_ser = o_q[0];

endmodule

/* verilog/alu_ctrl_fsm.sv */
`timescale 1ns/1ps

module alu_ctrl_fsm
   import serial_alu_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst_n,
   input  logic       i_start,
   input  alu_op_e    i_op,
   input  logic       i_last,
   output logic       o_load,
   output logic       o_shift,
   output logic       o_fill,
   output logic       o_pass_en,
   output logic       o_cnt_en,
   output logic       o_busy,
   output logic       o_done,
   output logic       o_sub,
   output logic [1:0] o_bool_sel,
   output logic [1:0] o_rd_sel,
   output logic       o_cmp_uns,
   output logic       o_cmp_eq,
   output logic       o_sh_right,
   output logic       o_sh_signed
);

   alu_state_e state;
   alu_op_e    op_q;
   logic       two_pass;

   // Shifts and set-less-than need the fill pass first.
   assign two_pass = (i_op == OP_SLL) || (i_op == OP_SRL) || (i_op == OP_SRA) ||
                     (i_op == OP_SLT) || (i_op == OP_SLTU);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
         op_q  <= OP_ADD;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_start) begin
                  op_q  <= i_op;
                  state <= two_pass ? ST_FILL : ST_RUN;
               end
            end
            ST_FILL: if (i_last) state <= ST_RUN;
            ST_RUN:  if (i_last) state <= ST_DONE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign o_load    = (state == ST_IDLE) && i_start;
   assign o_fill    = (state == ST_FILL);
   assign o_pass_en = (state == ST_FILL) || (state == ST_RUN);
   assign o_shift   = o_pass_en;
   assign o_cnt_en  = o_pass_en;
   assign o_busy    = (state != ST_IDLE);
   assign o_done    = (state == ST_DONE);

   // ####################
   // Opcode decode
   // ####################

   always_comb begin
      o_sub      = 1'b0;
      o_bool_sel = 2'd0;
      o_rd_sel   = RD_SEL_ADD;
      case (op_q)
         // EQ leaves the difference in the result word.
         OP_SUB, OP_EQ: o_sub = 1'b1;
         OP_AND:        o_rd_sel = RD_SEL_BOOL;
         OP_OR: begin
            o_bool_sel = 2'd1;
            o_rd_sel   = RD_SEL_BOOL;
         end
         OP_XOR: begin
            o_bool_sel = 2'd2;
            o_rd_sel   = RD_SEL_BOOL;
         end
         OP_SLT, OP_SLTU:       o_rd_sel = RD_SEL_LT;
         OP_SLL, OP_SRL, OP_SRA: o_rd_sel = RD_SEL_SH;
         default: o_rd_sel = RD_SEL_ADD;
      endcase
   end

   assign o_cmp_uns   = (op_q == OP_SLTU);
   assign o_cmp_eq    = (op_q == OP_EQ);
   assign o_sh_right  = (op_q == OP_SRL) || (op_q == OP_SRA);
   assign o_sh_signed = (op_q == OP_SRA);

   // Done follows the last bit of the run pass.
   a_done_after_run: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_done |-> (state == ST_DONE) && $past(state == ST_RUN && i_last));

endmodule

/* serial_alu/ser_adder.sv */
`timescale 1ns/1ps

module ser_adder (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_a,
   input  logic i_b,
   input  logic i_first,
   input  logic i_cin,
   output logic o_sum
);

   logic carry_q;
   logic carry;

   // Carry-in only counts on bit 0.
   assign carry = i_first ? i_cin : carry_q;
   assign o_sum = i_a ^ i_b ^ carry;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else begin
         carry_q <= (i_a & i_b) | (carry & (i_a ^ i_b));
      end
   end

endmodule

/* serial_alu/ser_shifter.sv */
`timescale 1ns/1ps

module ser_shifter
   import serial_alu_pkg::*;
(
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_fill,
   input  logic             i_d,
   input  logic             i_shamt_bit,
   input  logic [CNT_W-1:0] i_cnt,
   input  logic             i_right,
   input  logic             i_signed,
   output logic             o_q
);

   logic [XLEN-1:0]  sh_buf;
   logic [CNT_W-1:0] shamt_q;
   logic [CNT_W:0]   idx_r;
   logic [CNT_W:0]   idx_l;
   logic             sign_fill;

   // ####################
   // Fill pass
   // ####################

   always_ff @(posedge clk) begin
      if (i_fill) begin
         sh_buf <= {i_d, sh_buf[XLEN-1:1]};
      end
   end

   // Low five bits of B, arriving LSB first.
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         shamt_q <= '0;
      end else if (i_fill && (i_cnt < CNT_W)) begin
         shamt_q <= {i_shamt_bit, shamt_q[CNT_W-1:1]};
      end
   end

   // ####################
   // Run pass
   // ####################

   // Top bit of each index flags out of range.
   assign idx_r = {1'b0, i_cnt} + {1'b0, shamt_q};
   assign idx_l = {1'b0, i_cnt} - {1'b0, shamt_q};

   // A's MSB sits at the top of the buffer after fill.
   assign sign_fill = i_signed & sh_buf[XLEN-1];

   always_comb begin
      if (i_right) begin
         o_q = idx_r[CNT_W] ? sign_fill : sh_buf[idx_r[CNT_W-1:0]];
      end else begin
         o_q = idx_l[CNT_W] ? 1'b0 : sh_buf[idx_l[CNT_W-1:0]];
      end
   end

endmodule

/* serial_alu/serial_alu.sv */
`timescale 1ns/1ps

module serial_alu
   import serial_alu_pkg::*;
(
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_en,
   input  logic             i_rs1,
   input  logic             i_op_b,
   input  logic             i_first,
   input  logic             i_last,
   input  logic             i_fill,
   input  logic [CNT_W-1:0] i_cnt,
   input  logic             i_sub,
   input  logic [1:0]       i_bool_sel,
   input  logic             i_cmp_uns,
   input  logic             i_cmp_eq,
   input  logic             i_sh_right,
   input  logic             i_sh_signed,
   input  logic [1:0]       i_rd_sel,
   output logic             o_rd,
   output logic             o_cmp
);

   logic result_add;
   logic result_sh;
   logic result_bool;
   logic result_lt;
   logic lt_q;
   logic eq_q;
   logic lt_bit;
   logic eq_bit;
   logic bits_differ;

   // ####################
   // Adder and shifter
   // ####################

   ser_adder u_adder (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_a     (i_rs1),
      .i_b     (i_op_b ^ i_sub),
      .i_first (i_first),
      .i_cin   (i_sub),
      .o_sum   (result_add)
   );

   ser_shifter u_shifter (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_fill      (i_fill),
      .i_d         (i_rs1),
      .i_shamt_bit (i_op_b),
      .i_cnt       (i_cnt),
      .i_right     (i_sh_right),
      .i_signed    (i_sh_signed),
      .o_q         (result_sh)
   );

   assign result_bool = BOOL_LUT[{i_bool_sel, i_rs1, i_op_b}];

   // ####################
   // Compare
   // ####################

   assign bits_differ = i_rs1 ^ i_op_b;

   // Highest differing bit decides. A signed MSB of 1 means negative.
   assign lt_bit = bits_differ ? ((i_last && !i_cmp_uns) ? i_rs1 : i_op_b)
                               : (!i_first && lt_q);
   assign eq_bit = (i_first || eq_q) && !bits_differ;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         lt_q <= 1'b0;
         eq_q <= 1'b0;
      end else if (i_en) begin
         lt_q <= lt_bit;
         eq_q <= eq_bit;
      end
   end

   // Flag from the previous pass at bit 0, zeros above.
   assign result_lt = i_first & lt_q;

   always_comb begin
      case (i_rd_sel)
         RD_SEL_ADD:  o_rd = result_add;
         RD_SEL_SH:   o_rd = result_sh;
         RD_SEL_LT:   o_rd = result_lt;
         default:     o_rd = result_bool;
      endcase
   end

   assign o_cmp = i_cmp_eq ? eq_q : lt_q;

endmodule

/* verilog/serial_alu_top.sv */
`timescale 1ns/1ps

module serial_alu_top
   import serial_alu_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_start,
   input  alu_op_e         i_op,
   input  logic [XLEN-1:0] i_a,
   input  logic [XLEN-1:0] i_b,
   output logic            o_busy,
   output logic            o_done,
   output logic [XLEN-1:0] o_result,
   output logic            o_cmp
);

   logic             load;
   logic             shift;
   logic             fill;
   logic             pass_en;
   logic             cnt_en;
   logic             sub;
   logic [1:0]       bool_sel;
   logic [1:0]       rd_sel;
   logic             cmp_uns;
   logic             cmp_eq;
   logic             sh_right;
   logic             sh_signed;
   logic [CNT_W-1:0] cnt;
   logic             first;
   logic             last;
   logic             rs1_bit;
   logic             op_b_bit;
   logic             rd_bit;

   alu_ctrl_fsm u_ctrl (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_start     (i_start),
      .i_op        (i_op),
      .i_last      (last),
      .o_load      (load),
      .o_shift     (shift),
      .o_fill      (fill),
      .o_pass_en   (pass_en),
      .o_cnt_en    (cnt_en),
      .o_busy      (o_busy),
      .o_done      (o_done),
      .o_sub       (sub),
      .o_bool_sel  (bool_sel),
      .o_rd_sel    (rd_sel),
      .o_cmp_uns   (cmp_uns),
      .o_cmp_eq    (cmp_eq),
      .o_sh_right  (sh_right),
      .o_sh_signed (sh_signed)
   );

   bit_counter u_cnt (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_en    (cnt_en),
      .o_cnt   (cnt),
      .o_first (first),
      .o_last  (last)
   );

   // ####################
   // Operand and result registers
   // ####################

   operand_shreg opa (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_load   (load),
      .i_shift  (shift),
      .i_d      (i_a),
      .i_ser_in (1'b0),
      .i_recirc (1'b1),
      .o_ser    (rs1_bit),
      .o_q      ()
   );

   operand_shreg opb (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_load   (load),
      .i_shift  (shift),
      .i_d      (i_b),
      .i_ser_in (1'b0),
      .i_recirc (1'b1),
      .o_ser    (op_b_bit),
      .o_q      ()
   );

   // Result bits enter at the MSB.
   operand_shreg res (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_load   (1'b0),
      .i_shift  (shift),
      .i_d      ('0),
      .i_ser_in (rd_bit),
      .i_recirc (1'b0),
      .o_ser    (),
      .o_q      (o_result)
   );

   serial_alu u_alu (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_en        (pass_en),
      .i_rs1       (rs1_bit),
      .i_op_b      (op_b_bit),
      .i_first     (first),
      .i_last      (last),
      .i_fill      (fill),
      .i_cnt       (cnt),
      .i_sub       (sub),
      .i_bool_sel  (bool_sel),
      .i_cmp_uns   (cmp_uns),
      .i_cmp_eq    (cmp_eq),
      .i_sh_right  (sh_right),
      .i_sh_signed (sh_signed),
      .i_rd_sel    (rd_sel),
      .o_rd        (rd_bit),
      .o_cmp       (o_cmp)
   );

endmodule

/* tb/tb_serial_alu.sv */
`timescale 1ns/1ps

module tb_serial_alu
   import serial_alu_pkg::*;
();

   localparam int CLK_PERIOD       = 4;
   localparam int RESET_CYCLES     = 16;
   localparam int NUM_RANDOM       = 40;
   localparam int CYCLES_PER_ENTRY = 80;
   localparam int DONE_LIMIT       = 70;
   localparam int POKE_CYCLE       = 10;

   logic            clk;
   logic            i_rst_n;
   logic            i_start;
   alu_op_e         i_op;
   logic [XLEN-1:0] i_a;
   logic [XLEN-1:0] i_b;
   logic            o_busy;
   logic            o_done;
   logic [XLEN-1:0] o_result;
   logic            o_cmp;

   // Test table, one slot per entry in each queue.
   string           names[$];
   alu_op_e         ops[$];
   logic [XLEN-1:0] opnd_a[$];
   logic [XLEN-1:0] opnd_b[$];
   logic [XLEN-1:0] exp_result[$];
   logic            exp_cmp[$];
   logic            table_ready = 1'b0;

   serial_alu_top dut0 (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_start  (i_start),
      .i_op     (i_op),
      .i_a      (i_a),
      .i_b      (i_b),
      .o_busy   (o_busy),
      .o_done   (o_done),
      .o_result (o_result),
      .o_cmp    (o_cmp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ####################
   // Reference model
   // ####################

   function automatic logic takes_two_passes(input alu_op_e op);
      return (op == OP_SLL) || (op == OP_SRL) || (op == OP_SRA) ||
             (op == OP_SLT) || (op == OP_SLTU);
   endfunction

   function automatic logic [XLEN-1:0] expected_result(input alu_op_e op,
                                                       input logic [XLEN-1:0] a,
                                                       input logic [XLEN-1:0] b);
      logic [XLEN-1:0] r;
      case (op)
         OP_ADD:  r = a + b;
         OP_SUB:  r = a - b;
         OP_AND:  r = a & b;
         OP_OR:   r = a | b;
         OP_XOR:  r = a ^ b;
         OP_SLT:  r = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         OP_SLTU: r = {{(XLEN-1){1'b0}}, a < b};
         // EQ leaves the difference in the word.
         OP_EQ:   r = a - b;
         OP_SLL:  r = a << b[CNT_W-1:0];
         OP_SRL:  r = a >> b[CNT_W-1:0];
         OP_SRA:  r = $signed(a) >>> b[CNT_W-1:0];
         default: r = '0;
      endcase
      return r;
   endfunction

   function automatic logic expected_cmp(input alu_op_e op,
                                         input logic [XLEN-1:0] a,
                                         input logic [XLEN-1:0] b);
      if (op == OP_EQ) begin
         return a == b;
      end else if (op == OP_SLTU) begin
         return a < b;
      end
      return $signed(a) < $signed(b);
   endfunction

   // ####################
   // Helpers
   // ####################

   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
      if (actual !== expected) begin
         $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic push_entry(input string name, input alu_op_e op,
                             input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      names.push_back(name);
      ops.push_back(op);
      opnd_a.push_back(a);
      opnd_b.push_back(b);
      exp_result.push_back(expected_result(op, a, b));
      exp_cmp.push_back(expected_cmp(op, a, b));
   endtask

   task automatic directed_tests();
      int              amts [4] = '{0, 1, 17, 31};
      logic [XLEN-1:0] sh_b;
      push_entry("add_small", OP_ADD, 32'd5, 32'd7);
      push_entry("add_carry_chain", OP_ADD, 32'hffff_ffff, 32'd1);
      push_entry("add_msb_wrap", OP_ADD, 32'h8000_0000, 32'h8000_0001);
      push_entry("sub_small", OP_SUB, 32'd10, 32'd3);
      push_entry("sub_borrow_chain", OP_SUB, 32'd0, 32'd1);
      push_entry("and_mix", OP_AND, 32'ha5a5_a5a5, 32'h0ff0_0ff0);
      push_entry("or_mix", OP_OR, 32'ha5a5_a5a5, 32'h0ff0_0ff0);
      push_entry("xor_mix", OP_XOR, 32'ha5a5_a5a5, 32'h0ff0_0ff0);
      push_entry("slt_neg_pos", OP_SLT, 32'h8000_0000, 32'd1);
      push_entry("sltu_neg_pos", OP_SLTU, 32'h8000_0000, 32'd1);
      push_entry("slt_pos_neg", OP_SLT, 32'd1, 32'hffff_ffff);
      push_entry("sltu_pos_neg", OP_SLTU, 32'd1, 32'hffff_ffff);
      push_entry("slt_equal", OP_SLT, 32'h0000_1234, 32'h0000_1234);
      push_entry("sltu_low_bit", OP_SLTU, 32'h0000_1234, 32'h0000_1235);
      push_entry("eq_same", OP_EQ, 32'hdead_beef, 32'hdead_beef);
      push_entry("eq_lsb_diff", OP_EQ, 32'hdead_beef, 32'hdead_beee);
      push_entry("eq_msb_diff", OP_EQ, 32'd0, 32'h8000_0000);
      // Upper bits of B are set and must not affect the amount.
      foreach (amts[k]) begin
         sh_b = {27'h4d2_b3c1, CNT_W'(amts[k])};
         push_entry($sformatf("sll_%0d", amts[k]), OP_SLL, 32'h8bad_f00d, sh_b);
         push_entry($sformatf("srl_%0d", amts[k]), OP_SRL, 32'h8bad_f00d, sh_b);
         push_entry($sformatf("sra_neg_%0d", amts[k]), OP_SRA, 32'h8bad_f00d, sh_b);
         push_entry($sformatf("sra_pos_%0d", amts[k]), OP_SRA, 32'h7654_321f, sh_b);
      end
   endtask

   task automatic random_tests();
      alu_op_e         op;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      for (int i = 0; i < NUM_RANDOM; i++) begin
         op = alu_op_e'($urandom_range(10, 0));
         a  = $urandom();
         b  = $urandom();
         // Some equal pairs so EQ sees both outcomes.
         if ((i % 8) == 0) begin
            b = a;
         end
         push_entry($sformatf("rand%0d_%s", i, op.name()), op, a, b);
      end
   endtask

   // Called on a falling edge with the DUT idle.
   task automatic run_entry(input int unsigned idx);
      int unsigned cycles;
      int unsigned exp_cycles;
      cycles     = 0;
      exp_cycles = takes_two_passes(ops[idx]) ? 65 : 33;
      i_op    = ops[idx];
      i_a     = opnd_a[idx];
      i_b     = opnd_b[idx];
      i_start = 1'b1;
      while (o_done !== 1'b1) begin
         @(negedge clk);
         cycles++;
         if (cycles == 1) begin
            i_start = 1'b0;
            check_value({names[idx], " busy"}, XLEN'(1), XLEN'(o_busy));
         end
         // Start while busy, with other operands.
         if (cycles == POKE_CYCLE) begin
            i_start = 1'b1;
            i_op    = OP_XOR;
            i_a     = ~opnd_a[idx];
            i_b     = ~opnd_b[idx];
         end else if (cycles == POKE_CYCLE + 1) begin
            i_start = 1'b0;
         end
         if (cycles > DONE_LIMIT) begin
            $display("ERROR: test %s got no done pulse within %0d cycles",
                     names[idx], DONE_LIMIT);
            abort_run();
         end
      end
      check_value({names[idx], " latency"}, XLEN'(exp_cycles), XLEN'(cycles));
      check_value({names[idx], " result"}, exp_result[idx], o_result);
      check_value({names[idx], " cmp"}, XLEN'(exp_cmp[idx]), XLEN'(o_cmp));
      check_value({names[idx], " busy at done"}, XLEN'(1), XLEN'(o_busy));
      @(negedge clk);
      check_value({names[idx], " done width"}, '0, XLEN'(o_done));
      check_value({names[idx], " result hold"}, exp_result[idx], o_result);
      check_value({names[idx], " cmp hold"}, XLEN'(exp_cmp[idx]), XLEN'(o_cmp));
   endtask

   // ####################
   // Main sequence
   // ####################

   initial begin : main
      int unsigned idx;
      i_rst_n = 1'b0;
      i_start = 1'b0;
      i_op    = OP_ADD;
      i_a     = '0;
      i_b     = '0;
      void'($urandom(32'ha17b));
      directed_tests();
      random_tests();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk);
      i_rst_n = 1'b1;
      check_value("reset busy", '0, XLEN'(o_busy));
      check_value("reset done", '0, XLEN'(o_done));
      for (idx = 0; idx < ops.size(); idx++) begin
         run_entry(idx);
      end
      $display("=== PASS ===");
      $finish;
   end

   initial begin : watchdog
      int unsigned limit;
      wait (table_ready);
      limit = ops.size() * CYCLES_PER_ENTRY + RESET_CYCLES;
      repeat (limit) @(posedge clk);
      $display("ERROR: timeout, the run did not finish within %0d cycles", limit);
      abort_run();
   end

endmodule

/* flist.f */
common/serial_alu_pkg.sv
verilog/bit_counter.sv
verilog/operand_shreg.sv
verilog/alu_ctrl_fsm.sv
serial_alu/ser_adder.sv
serial_alu/ser_shifter.sv
serial_alu/serial_alu.sv
verilog/serial_alu_top.sv
tb/tb_serial_alu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the serial ALU testbench with Verilator.
set -u

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "Cannot enter the project directory"
   exit 1
fi

TOP=tb_serial_alu
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f flist.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if ! grep -q "=== PASS ===" "$LOG"; then
   echo "Simulation ended without a result"
   exit 1
fi

echo "Simulation passed"
exit 0
